//--- rob_settings.svh
// Reorder buffer settings
`ifndef ROB_SETTINGS_SVH
`define ROB_SETTINGS_SVH

// log2 of the record count, 3 to 5 work
`define ROB_DEPTH_BITS 4

// Result and address width
`define ROB_DATA_W 32

// Register index width
`define ROB_REG_W 5

`endif

//--- rob_pkg.sv
// Reorder buffer types
`include "rob_settings.svh"

package rob_pkg;

  // Free records sit in IGNORE
  typedef enum logic [1:0] {
    WAITING,
    COMPLETED,
    IGNORE
  } rob_status_e;

  typedef struct packed {
    logic jumps;
    logic writes;
    logic mem;
    logic spec;
  } rob_flags_t;

  typedef struct packed {
    logic                   valid;
    logic [`ROB_DATA_W-1:0] pc;
    logic [`ROB_REG_W-1:0]  rd;
    rob_flags_t             flags;
  } rob_issue_t;

  // Tag is the record index
  typedef struct packed {
    logic                       valid;
    logic [`ROB_DEPTH_BITS-1:0] tag;
    logic [`ROB_DATA_W-1:0]     result;
    logic [`ROB_DATA_W-1:0]     target;
  } rob_complete_t;

  typedef struct packed {
    logic [`ROB_DATA_W-1:0] pc;
    logic [`ROB_DATA_W-1:0] result;
    logic [`ROB_DATA_W-1:0] target;
    logic [`ROB_REG_W-1:0]  rd;
    rob_flags_t             flags;
    rob_status_e            status;
  } rob_record_t;

  typedef struct packed {
    logic [`ROB_DEPTH_BITS-1:0] tag;
    logic [`ROB_DATA_W-1:0]     pc;
    logic [`ROB_DATA_W-1:0]     result;
    logic [`ROB_REG_W-1:0]      rd;
    logic                       reg_write;
    logic                       mem_write;
  } rob_commit_t;

endpackage

//--- reorder_buffer.sv
// Reorder buffer storage and head control
`timescale 1ns/1ns
`include "rob_settings.svh"

module reorder_buffer (
  input  logic                       cs,
  input  logic                       i_arst_n,
  input  rob_pkg::rob_issue_t        i_issue [2],
  output logic [`ROB_DEPTH_BITS-1:0] o_issue_tag,
  output logic                       o_full,
  input  rob_pkg::rob_complete_t     i_complete [2],
  output logic                       o_head_ready,
  output rob_pkg::rob_record_t       o_head,
  input  logic                       i_spec_clear,
  input  logic                       i_spec_flush,
  output logic                       o_retire_valid,
  output rob_pkg::rob_commit_t       o_retire,
  input  logic                       i_retire_take
);
  import rob_pkg::*;

  localparam int DB = `ROB_DEPTH_BITS;
  localparam int DEPTH = 1 << DB;
  localparam logic [DB:0] FULL_AT = (DB+1)'(DEPTH - 1);

  // Record fields
  logic [`ROB_DATA_W-1:0] pc_q     [DEPTH];
  logic [`ROB_DATA_W-1:0] result_q [DEPTH];
  logic [`ROB_DATA_W-1:0] target_q [DEPTH];
  logic [`ROB_REG_W-1:0]  rd_q     [DEPTH];
  rob_flags_t             flags_q  [DEPTH];
  rob_status_e            status_q [DEPTH];

  logic [DB-1:0] head_q;
  logic [DB-1:0] tail_q;
  logic [DB-1:0] tail_p1;
  logic [DB:0]   count_q;
  logic [DB:0]   issue_n;
  logic          resolved_q;
  logic          issue_ok0;
  logic          issue_ok1;
  logic          head_valid;
  logic          head_advance;
  rob_flags_t    new_flags0;
  rob_flags_t    new_flags1;

  assign tail_p1     = tail_q + 1'b1;
  assign o_issue_tag = tail_q;
  // Full once fewer than two records are free
  assign o_full      = (count_q >= FULL_AT);

  assign issue_ok0 = i_issue[0].valid && !o_full;
  assign issue_ok1 = issue_ok0 && i_issue[1].valid;
  assign issue_n   = {{DB{1'b0}}, issue_ok0} + {{DB{1'b0}}, issue_ok1};

  // Resolution in the issue cycle applies to the new records too
  always_comb begin
    new_flags0      = i_issue[0].flags;
    new_flags0.spec = i_issue[0].flags.spec && !i_spec_clear;
    new_flags1      = i_issue[1].flags;
    new_flags1.spec = i_issue[1].flags.spec && !i_spec_clear;
  end

  assign head_valid = (count_q != '0);

  always_comb begin
    o_retire_valid = 1'b0;
    if (head_valid && status_q[head_q] == COMPLETED) begin
      if (!flags_q[head_q].jumps) begin
        o_retire_valid = 1'b1;
      end else begin
        // Jumps wait for the branch check
        o_retire_valid = resolved_q || i_spec_clear || i_spec_flush;
      end
    end
  end

  assign head_advance = head_valid &&
                        (status_q[head_q] == IGNORE || (o_retire_valid && i_retire_take));
  assign o_head_ready = head_valid && !resolved_q;

  assign o_head = '{pc: pc_q[head_q], result: result_q[head_q], target: target_q[head_q],
                    rd: rd_q[head_q], flags: flags_q[head_q], status: status_q[head_q]};

  assign o_retire = '{tag: head_q, pc: pc_q[head_q], result: result_q[head_q],
                      rd: rd_q[head_q], reg_write: flags_q[head_q].writes,
                      mem_write: flags_q[head_q].mem & flags_q[head_q].writes};

  // Payload writes
  always_ff @(posedge cs) begin
    if (i_spec_clear) begin
      for (int i = 0; i < DEPTH; i++) begin
        flags_q[i].spec <= 1'b0;
      end
    end
    for (int p = 0; p < 2; p++) begin
      if (i_complete[p].valid) begin
        result_q[i_complete[p].tag] <= i_complete[p].result;
        target_q[i_complete[p].tag] <= i_complete[p].target;
      end
    end
    if (issue_ok0) begin
      pc_q[tail_q]    <= i_issue[0].pc;
      rd_q[tail_q]    <= i_issue[0].rd;
      flags_q[tail_q] <= new_flags0;
    end
    if (issue_ok1) begin
      pc_q[tail_p1]    <= i_issue[1].pc;
      rd_q[tail_p1]    <= i_issue[1].rd;
      flags_q[tail_p1] <= new_flags1;
    end
  end

  // Record status, later updates take priority
  always_ff @(posedge cs or negedge i_arst_n) begin
    if (!i_arst_n) begin
      for (int i = 0; i < DEPTH; i++) begin
        status_q[i] <= IGNORE;
      end
    end else begin
      for (int p = 0; p < 2; p++) begin
        if (i_complete[p].valid && status_q[i_complete[p].tag] != IGNORE) begin
          status_q[i_complete[p].tag] <= COMPLETED;
        end
      end
      if (head_advance) begin
        status_q[head_q] <= IGNORE;
      end
      if (i_spec_flush) begin
        // The resolving jump itself stays
        for (int i = 0; i < DEPTH; i++) begin
          if (flags_q[i].spec && DB'(i) != head_q) begin
            status_q[i] <= IGNORE;
          end
        end
      end
      if (issue_ok0) begin
        status_q[tail_q] <= (i_spec_flush && i_issue[0].flags.spec) ? IGNORE : WAITING;
      end
      if (issue_ok1) begin
        status_q[tail_p1] <= (i_spec_flush && i_issue[1].flags.spec) ? IGNORE : WAITING;
      end
    end
  end

  always_ff @(posedge cs or negedge i_arst_n) begin
    if (!i_arst_n) begin
      head_q     <= '0;
      tail_q     <= '0;
      count_q    <= '0;
      resolved_q <= 1'b0;
    end else begin
      tail_q  <= tail_q + issue_n[DB-1:0];
      count_q <= count_q + issue_n - {{DB{1'b0}}, head_advance};
      if (head_advance) begin
        head_q     <= head_q + 1'b1;
        resolved_q <= 1'b0;
      end else if (i_spec_clear || i_spec_flush) begin
        resolved_q <= 1'b1;
      end
    end
  end

  // Issue slots fill in order
  a_issue_order: assert property (@(posedge cs) disable iff (!i_arst_n)
    i_issue[1].valid |-> i_issue[0].valid);

  for (genvar p = 0; p < 2; p++) begin : g_cpl_chk
    a_cpl_live: assert property (@(posedge cs) disable iff (!i_arst_n)
      i_complete[p].valid |-> status_q[i_complete[p].tag] != IGNORE);
  end

  a_count_max: assert property (@(posedge cs) disable iff (!i_arst_n)
    count_q <= (DB+1)'(DEPTH));

endmodule

//--- branch_check.sv
// Jump resolution at the buffer head
`timescale 1ns/1ns
`include "rob_settings.svh"

module branch_check (
  input  logic                   cs,
  input  logic                   i_arst_n,
  input  logic                   i_head_ready,
  input  rob_pkg::rob_record_t   i_head,
  output logic                   o_spec_clear,
  output logic                   o_spec_flush,
  output logic                   o_redirect_valid,
  output logic [`ROB_DATA_W-1:0] o_redirect_pc
);
  import rob_pkg::*;

  logic                   decide;
  logic                   falls_through;
  logic [`ROB_DATA_W-1:0] next_pc;

  // One decision per jump, none while the last one is out
  assign decide = i_head_ready && i_head.flags.jumps && (i_head.status == COMPLETED) &&
                  !(o_spec_clear || o_spec_flush);

  assign next_pc       = i_head.pc + 3'd4;
  assign falls_through = (i_head.target == next_pc);

  always_ff @(posedge cs or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_spec_clear <= 1'b0;
      o_spec_flush <= 1'b0;
    end else begin
      o_spec_clear <= decide && falls_through;
      o_spec_flush <= decide && !falls_through;
    end
  end

  always_ff @(posedge cs) begin
    if (decide && !falls_through) begin
      o_redirect_pc <= i_head.target;
    end
  end

  // Redirect goes out with the flush
  assign o_redirect_valid = o_spec_flush;

  a_one_outcome: assert property (@(posedge cs) disable iff (!i_arst_n)
    !(o_spec_clear && o_spec_flush));

endmodule

//--- commit_arbiter.sv
// Dual commit bus sequencer
`timescale 1ns/1ns

module commit_arbiter (
  input  logic                 cs,
  input  logic                 i_arst_n,
  input  logic                 i_retire_valid,
  input  rob_pkg::rob_commit_t i_retire,
  output logic                 o_retire_take,
  output logic                 o_commit_req [2],
  output rob_pkg::rob_commit_t o_commit [2],
  input  logic                 i_commit_ack [2]
);
  import rob_pkg::*;

  // Handshake phases
  localparam logic [1:0] PH_IDLE = 2'd0;
  localparam logic [1:0] PH_REQ  = 2'd1;
  localparam logic [1:0] PH_DROP = 2'd2;

  logic [1:0]  phase_q [2];
  rob_commit_t hold_q  [2];
  logic [1:0]  bus_free;
  logic [1:0]  bus_load;

  // Lower idle bus wins
  assign o_retire_take = i_retire_valid && (bus_free != 2'b00);
  assign bus_load[0]   = o_retire_take && bus_free[0];
  assign bus_load[1]   = o_retire_take && !bus_free[0];

  for (genvar b = 0; b < 2; b++) begin : g_bus
    // Free only with req and ack both low
    assign bus_free[b] = (phase_q[b] == PH_IDLE) && !i_commit_ack[b];

    always_ff @(posedge cs or negedge i_arst_n) begin
      if (!i_arst_n) begin
        phase_q[b] <= PH_IDLE;
      end else begin
        case (phase_q[b])
          PH_IDLE: if (bus_load[b]) phase_q[b] <= PH_REQ;
          PH_REQ:  if (i_commit_ack[b]) phase_q[b] <= PH_DROP;
          PH_DROP: if (!i_commit_ack[b]) phase_q[b] <= PH_IDLE;
          default: phase_q[b] <= PH_IDLE;
        endcase
      end
    end

    always_ff @(posedge cs) begin
      if (bus_load[b]) begin
        hold_q[b] <= i_retire;
      end
    end

    assign o_commit_req[b] = (phase_q[b] == PH_REQ);
    assign o_commit[b]     = hold_q[b];

    a_req_held: assert property (@(posedge cs) disable iff (!i_arst_n)
      $fell(o_commit_req[b]) |-> $past(i_commit_ack[b]));

    a_data_stable: assert property (@(posedge cs) disable iff (!i_arst_n)
      o_commit_req[b] && $past(o_commit_req[b]) |-> $stable(o_commit[b]));
  end

endmodule

//--- rob_top.sv
// Reorder buffer subsystem top
`timescale 1ns/1ns
`include "rob_settings.svh"

module rob_top (
  input  logic                       cs,
  input  logic                       i_arst_n,
  input  rob_pkg::rob_issue_t        i_issue [2],
  output logic [`ROB_DEPTH_BITS-1:0] o_issue_tag,
  output logic                       o_full,
  input  rob_pkg::rob_complete_t     i_complete [2],
  output logic                       o_commit_req [2],
  output rob_pkg::rob_commit_t       o_commit [2],
  input  logic                       i_commit_ack [2],
  output logic                       o_redirect_valid,
  output logic [`ROB_DATA_W-1:0]     o_redirect_pc
);
  import rob_pkg::*;

  // Head to branch check
  logic        head_ready;
  rob_record_t head;
  logic        spec_clear;
  logic        spec_flush;

  // Retirement to the commit buses
  logic        retire_valid;
  rob_commit_t retire;
  logic        retire_take;

  reorder_buffer u_rob (
    .cs             (cs),
    .i_arst_n       (i_arst_n),
    .i_issue        (i_issue),
    .o_issue_tag    (o_issue_tag),
    .o_full         (o_full),
    .i_complete     (i_complete),
    .o_head_ready   (head_ready),
    .o_head         (head),
    .i_spec_clear   (spec_clear),
    .i_spec_flush   (spec_flush),
    .o_retire_valid (retire_valid),
    .o_retire       (retire),
    .i_retire_take  (retire_take)
  );

  branch_check u_branch (
    .cs               (cs),
    .i_arst_n         (i_arst_n),
    .i_head_ready     (head_ready),
    .i_head           (head),
    .o_spec_clear     (spec_clear),
    .o_spec_flush     (spec_flush),
    .o_redirect_valid (o_redirect_valid),
    .o_redirect_pc    (o_redirect_pc)
  );

  commit_arbiter u_arbiter (
    .cs             (cs),
    .i_arst_n       (i_arst_n),
    .i_retire_valid (retire_valid),
    .i_retire       (retire),
    .o_retire_take  (retire_take),
    .o_commit_req   (o_commit_req),
    .o_commit       (o_commit),
    .i_commit_ack   (i_commit_ack)
  );

endmodule

//--- tb_rob_checks.svh
// Testbench scoreboard and helpers
`ifndef TB_ROB_CHECKS_SVH
`define TB_ROB_CHECKS_SVH

localparam int          DB         = `ROB_DEPTH_BITS;
localparam int          DEPTH      = 1 << DB;
localparam int          TEST_COUNT = 6;
localparam int          TEST_SPAN  = 300;
// Six tests of about 300 cycles, plus reset
localparam int          MAX_CYCLES = TEST_COUNT * TEST_SPAN + 200;
localparam logic [31:0] SEED       = 32'h8424;

// Flag sets as {jumps, writes, mem, spec}
localparam logic [3:0] F_ALU   = 4'b0100;
localparam logic [3:0] F_STORE = 4'b0110;
localparam logic [3:0] F_MEM   = 4'b0010;
localparam logic [3:0] F_NONE  = 4'b0000;
localparam logic [3:0] F_JUMP  = 4'b1100;
localparam logic [3:0] F_SPEC  = 4'b0101;

// Expected commits in program order, flushed records left out
rob_commit_t            sb_q [$];
rob_commit_t            exp_front;
logic                   exp_valid;
rob_commit_t            rec_by_tag [DEPTH];
logic [`ROB_DATA_W-1:0] tgt_by_tag [DEPTH];

logic                   redirect_expected;
logic [`ROB_DATA_W-1:0] exp_redirect_pc;
logic [31:0]            rng;
int                     errors;
int                     test_base;
int                     tests_done;
int                     commits;
int                     redirects;
int                     bus_commits [2];

function automatic logic [31:0] xorshift32(input logic [31:0] x);
  logic [31:0] y;
  y = x ^ (x << 13);
  y = y ^ (y >> 17);
  y = y ^ (y << 5);
  return y;
endfunction

function automatic logic [31:0] rand_word();
  rng = xorshift32(rng);
  return rng;
endfunction

// Valid slot with a random destination register
function automatic rob_issue_t make_slot(input logic [31:0] pc, input logic [3:0] flags);
  rob_issue_t  s;
  logic [31:0] w;
  w       = rand_word();
  s.valid = 1'b1;
  s.pc    = pc;
  s.rd    = w[`ROB_REG_W-1:0];
  s.flags = flags;
  return s;
endfunction

function automatic void refresh_front();
  exp_valid = (sb_q.size() != 0);
  if (exp_valid) begin
    exp_front = sb_q[0];
  end else begin
    exp_front = '0;
  end
endfunction

// Expected commit fields follow the flag rules
function automatic void note_record(input logic [DB-1:0] tag, input rob_issue_t s,
                                    input logic keep);
  rob_commit_t r;
  r.tag       = tag;
  r.pc        = s.pc;
  r.result    = rand_word();
  r.rd        = s.rd;
  r.reg_write = s.flags.writes;
  r.mem_write = s.flags.mem && s.flags.writes;
  rec_by_tag[tag] = r;
  tgt_by_tag[tag] = s.pc + 32'd4;
  if (keep) begin
    sb_q.push_back(r);
    refresh_front();
  end
endfunction

task automatic drive_cycle(input rob_issue_t s0, input rob_issue_t s1,
                           input rob_complete_t c0, input rob_complete_t c1);
  @(negedge cs);
  issue[0]    = s0;
  issue[1]    = s1;
  complete[0] = c0;
  complete[1] = c1;
endtask

// Slot 1 takes part when its valid bit is set
task automatic issue_records(input rob_issue_t s0, input rob_issue_t s1,
                             input logic keep0, input logic keep1,
                             output logic [DB-1:0] tag0, output logic taken);
  drive_cycle(s0, s1, '0, '0);
  tag0  = issue_tag;
  taken = !full;
  if (taken) begin
    note_record(tag0, s0, keep0);
    if (s1.valid) begin
      note_record(tag0 + 1'b1, s1, keep1);
    end
  end
endtask

task automatic complete_records(input logic [DB-1:0] ta, input logic [DB-1:0] tb,
                                input logic two);
  rob_complete_t c0;
  rob_complete_t c1;
  c0.valid  = 1'b1;
  c0.tag    = ta;
  c0.result = rec_by_tag[ta].result;
  c0.target = tgt_by_tag[ta];
  c1.valid  = two;
  c1.tag    = tb;
  c1.result = rec_by_tag[tb].result;
  c1.target = tgt_by_tag[tb];
  drive_cycle('0, '0, c0, c1);
endtask

// Idle inputs until every expected commit has finished its handshake
task automatic wait_drain();
  drive_cycle('0, '0, '0, '0);
  while (sb_q.size() != 0 || commit_req[0] || commit_req[1] ||
         commit_ack[0] || commit_ack[1]) begin
    @(negedge cs);
  end
endtask

task automatic expect_true(input logic cond, input string what);
  a_expect: assert (cond) else begin
    errors++;
    $display("FAIL %0t: %s", $time, what);
  end
endtask

task automatic finish_test(input string name);
  $display("%s finished with %0d errors", name, errors - test_base);
  test_base = errors;
  tests_done++;
endtask

`endif

//--- tb_rob_top.sv
// Reorder buffer testbench
`timescale 1ns/1ns
`include "rob_settings.svh"

module tb_rob_top;
  import rob_pkg::*;

  logic                       cs;
  logic                       i_arst_n;
  rob_issue_t                 issue [2];
  logic [`ROB_DEPTH_BITS-1:0] issue_tag;
  logic                       full;
  rob_complete_t              complete [2];
  logic                       commit_req [2];
  rob_commit_t                commit [2];
  logic                       commit_ack [2];
  logic                       redirect_valid;
  logic [`ROB_DATA_W-1:0]     redirect_pc;

  logic                       req_seen [2];
  logic [1:0]                 ack_wait [2];
  logic [31:0]                ack_rng;
  int                         cycles;

  `include "tb_rob_checks.svh"

  rob_top dut0 (
    .cs               (cs),
    .i_arst_n         (i_arst_n),
    .i_issue          (issue),
    .o_issue_tag      (issue_tag),
    .o_full           (full),
    .i_complete       (complete),
    .o_commit_req     (commit_req),
    .o_commit         (commit),
    .i_commit_ack     (commit_ack),
    .o_redirect_valid (redirect_valid),
    .o_redirect_pc    (redirect_pc)
  );

  initial begin
    cs = 1'b0;
    forever #10 cs = ~cs;
  end

  // Pop the scoreboard at each req rising edge
  always @(posedge cs) begin
    for (int b = 0; b < 2; b++) begin
      if (i_arst_n && commit_req[b] && !req_seen[b]) begin
        bus_commits[b]++;
        commits++;
        if (sb_q.size() != 0) begin
          sb_q.delete(0);
        end
      end
      req_seen[b] = i_arst_n && commit_req[b];
    end
    refresh_front();
    if (i_arst_n && redirect_valid) begin
      redirects++;
    end
  end

  always @(posedge cs) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: run stopped after %0d cycles", cycles);
      $display("TEST FAILED");
      $finish;
    end
  end

  // Commit consumer acks after 0 to 3 cycles
  always @(negedge cs) begin
    for (int b = 0; b < 2; b++) begin
      if (!i_arst_n) begin
        commit_ack[b] = 1'b0;
        ack_wait[b]   = 2'd0;
      end else if (commit_ack[b]) begin
        if (!commit_req[b]) begin
          commit_ack[b] = 1'b0;
        end
      end else if (commit_req[b]) begin
        if (ack_wait[b] == 2'd0) begin
          commit_ack[b] = 1'b1;
          ack_rng       = xorshift32(ack_rng);
          ack_wait[b]   = ack_rng[1:0];
        end else begin
          ack_wait[b] = ack_wait[b] - 2'd1;
        end
      end
    end
  end

  for (genvar b = 0; b < 2; b++) begin : g_commit_chk
    a_commit_match: assert property (@(posedge cs) disable iff (!i_arst_n)
      $rose(commit_req[b]) |-> exp_valid && commit[b] == exp_front)
      else begin
        errors++;
        $display("FAIL %0t: bus %0d commit tag %0d pc %h does not match the expected record",
                 $time, b, commit[b].tag, commit[b].pc);
      end
  end

  a_redirect_match: assert property (@(posedge cs) disable iff (!i_arst_n)
    redirect_valid |-> redirect_expected && redirect_pc == exp_redirect_pc)
    else begin
      errors++;
      $display("FAIL %0t: redirect to %h, expected %0d to %h", $time, redirect_pc,
               redirect_expected, exp_redirect_pc);
    end

  task automatic check_reset_state();
    logic [DB-1:0] tag0;
    logic          taken;
    expect_true(!full && !commit_req[0] && !commit_req[1], "o_full or req high after reset");
    expect_true(!redirect_valid, "redirect high after reset");
    issue_records(make_slot(32'h100, F_ALU), '0, 1'b1, 1'b0, tag0, taken);
    expect_true(taken && tag0 == '0, "first issue did not get tag 0");
    complete_records(tag0, tag0, 1'b0);
    wait_drain();
    finish_test("reset_state");
  endtask

  task automatic complete_in_reverse();
    logic [DB-1:0] t0;
    logic [DB-1:0] t2;
    logic          taken;
    issue_records(make_slot(32'h200, F_ALU), make_slot(32'h204, F_STORE), 1'b1, 1'b1,
                  t0, taken);
    issue_records(make_slot(32'h208, F_MEM), make_slot(32'h20c, F_NONE), 1'b1, 1'b1,
                  t2, taken);
    complete_records(t2 + 1'b1, t2, 1'b1);
    complete_records(t0 + 1'b1, t0, 1'b1);
    wait_drain();
    finish_test("reverse_complete");
  endtask

  task automatic fill_buffer();
    logic [DB-1:0] base;
    logic [DB-1:0] tag0;
    logic          taken;
    logic [31:0]   pc;
    int            cnt;
    cnt  = 0;
    base = '0;
    while (cnt < DEPTH - 1) begin
      pc = 32'h1000 + 32'(4 * cnt);
      if (cnt + 2 <= DEPTH - 1) begin
        issue_records(make_slot(pc, F_ALU), make_slot(pc + 32'd4, F_ALU), 1'b1, 1'b1,
                      tag0, taken);
      end else begin
        issue_records(make_slot(pc, F_ALU), '0, 1'b1, 1'b0, tag0, taken);
      end
      expect_true(full == (cnt >= DEPTH - 1), "o_full does not match the free records");
      if (cnt == 0) begin
        base = tag0;
      end
      if (taken) begin
        cnt = (cnt + 2 <= DEPTH - 1) ? cnt + 2 : cnt + 1;
      end
    end
    // Attempts while full must be dropped
    for (int k = 0; k < 3; k++) begin
      issue_records(make_slot(32'h1800, F_ALU), make_slot(32'h1804, F_ALU), 1'b0, 1'b0,
                    tag0, taken);
      expect_true(full, "o_full low with fewer than two free records");
    end
    for (int i = 0; i < cnt; i += 2) begin
      complete_records(base + DB'(i), base + DB'(i + 1), i + 1 < cnt);
    end
    wait_drain();
    finish_test("fill");
  endtask

  // Jump at the head with two younger spec records
  task automatic resolve_jump(input logic mispredict, input logic [31:0] pc);
    logic [DB-1:0] tj;
    logic [DB-1:0] ts;
    logic          taken;
    int            seen;
    seen = redirects;
    issue_records(make_slot(pc, F_JUMP), make_slot(pc + 32'd4, F_SPEC), 1'b1, !mispredict,
                  tj, taken);
    issue_records(make_slot(pc + 32'd8, F_SPEC), '0, !mispredict, 1'b0, ts, taken);
    complete_records(tj + 1'b1, ts, 1'b1);
    if (mispredict) begin
      tgt_by_tag[tj]    = pc + 32'h40;
      exp_redirect_pc   = pc + 32'h40;
      redirect_expected = 1'b1;
    end
    complete_records(tj, tj, 1'b0);
    wait_drain();
    redirect_expected = 1'b0;
    expect_true(redirects == seen + int'(mispredict), "wrong number of redirects");
    finish_test(mispredict ? "jump_redirect" : "jump_fall_through");
  endtask

  task automatic shuffle_with_random_acks();
    logic [DB-1:0] tags [12];
    logic [DB-1:0] tag0;
    logic [DB-1:0] swap;
    logic          taken;
    logic [31:0]   w;
    int            used [2];
    int            j;
    used[0] = bus_commits[0];
    used[1] = bus_commits[1];
    for (int i = 0; i < 12; i += 2) begin
      w = rand_word();
      issue_records(make_slot(32'h3000 + 32'(4 * i), {1'b0, w[8], w[9], 1'b0}),
                    make_slot(32'h3004 + 32'(4 * i), {1'b0, w[10], w[11], 1'b0}),
                    1'b1, 1'b1, tag0, taken);
      tags[i]     = tag0;
      tags[i + 1] = tag0 + 1'b1;
    end
    // Shuffle the completion order
    for (int i = 11; i > 0; i--) begin
      w       = rand_word();
      j       = int'(w % 32'(i + 1));
      swap    = tags[i];
      tags[i] = tags[j];
      tags[j] = swap;
    end
    for (int i = 0; i < 12; i += 2) begin
      complete_records(tags[i], tags[i + 1], 1'b1);
    end
    wait_drain();
    expect_true(bus_commits[0] > used[0] && bus_commits[1] > used[1],
                "one commit bus carried no commits");
    finish_test("random_ack");
  endtask

  initial begin
    i_arst_n          = 1'b0;
    issue[0]          = '0;
    issue[1]          = '0;
    complete[0]       = '0;
    complete[1]       = '0;
    commit_ack[0]     = 1'b0;
    commit_ack[1]     = 1'b0;
    req_seen[0]       = 1'b0;
    req_seen[1]       = 1'b0;
    rng               = SEED;
    ack_rng           = SEED;
    redirect_expected = 1'b0;
    exp_redirect_pc   = '0;
    refresh_front();
    repeat (5) @(posedge cs);
    @(negedge cs);
    i_arst_n = 1'b1;

    check_reset_state();
    complete_in_reverse();
    fill_buffer();
    resolve_jump(1'b0, 32'h2000);
    resolve_jump(1'b1, 32'h2100);
    shuffle_with_random_acks();

    $display("%0d tests run, %0d commits checked, %0d errors", tests_done, commits, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- sources.f
+incdir+.
rob_pkg.sv
reorder_buffer.sv
branch_check.sv
commit_arbiter.sv
rob_top.sv
tb_rob_top.sv

//--- Makefile
# Reorder buffer simulation with Verilator

VERILATOR ?= verilator
TOP       ?= tb_rob_top
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns -j 0

SRCS := $(filter-out +incdir+%,$(shell cat $(FILELIST)))
HDRS := rob_settings.svh tb_rob_checks.svh
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(BIN) | tee $(LOG)
	@grep -q "^TEST OK$$" $(LOG) || (echo "simulation did not pass, see $(LOG)" && exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
